/* logic/dcache_pkg.sv */
package dcache_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int DC_ADDR_W  = 32;  // byte address
    localparam int DC_DATA_W  = 32;  // one word per line
    localparam int DC_STRB_W  = 4;   // byte strobes per word
    localparam int DC_INDEX_W = 4;   // 16 sets unless the top overrides

    // lru is a single bit per set, so this stays at two
    localparam int DC_WAYS = 2;

    //////////////////////////////////////////////////
    // pipeline operation
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_INVAL = 2'd2   // drop both ways of the set
    } dc_op_e;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_LOOKUP      = 3'd1,
        ST_REFILL_REQ  = 3'd2,  // read addr out, wait addr_ok
        ST_REFILL_WAIT = 3'd3,  // wait data_ok
        ST_REFILL_HOLD = 3'd4,  // extra beat while pipeline holds
        ST_REFILL_DONE = 3'd5,
        ST_WRITE_THRU  = 3'd6,
        ST_INVAL       = 3'd7
    } dc_state_e;

endpackage

/* logic/dcache_req_buf.sv */
`timescale 1ns/1ps

module dcache_req_buf (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             we,
    input  dcache_pkg::dc_op_e               req_op,
    input  logic [dcache_pkg::DC_ADDR_W-1:0] req_addr,
    input  logic [dcache_pkg::DC_DATA_W-1:0] req_wdata,
    input  logic [dcache_pkg::DC_STRB_W-1:0] req_wstrb,
    output dcache_pkg::dc_op_e               buf_op,
    output logic [dcache_pkg::DC_ADDR_W-1:0] buf_addr,
    output logic [dcache_pkg::DC_DATA_W-1:0] buf_wdata,
    output logic [dcache_pkg::DC_STRB_W-1:0] buf_wstrb
);
    import dcache_pkg::*;

    //////////////////////////////////////////////////
    // op register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_op <= OP_LOAD;
        end else if (we) begin
            buf_op <= req_op;
        end
    end

    //////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (we) begin
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;  // only meaningful for stores
            buf_wstrb <= req_wstrb;
        end
    end

endmodule

/* logic/dcache_lru.sv */
`timescale 1ns/1ps

module dcache_lru #(
    parameter int index_width = dcache_pkg::DC_INDEX_W
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use0,
    input  logic                   use1,
    output logic                   victim
);
    localparam int num_sets = 1 << index_width;

    logic [num_sets-1:0] lru_q;  // 1 means way 1 goes next

    assign victim = lru_q[index];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use0) begin
            lru_q[index] <= 1'b1;  // way 0 touched, evict way 1
        end else if (use1) begin
            lru_q[index] <= 1'b0;
        end
    end

    // controller touches one way per cycle
    a_use_onehot: assert property (@(posedge clk) disable iff (!rstn)
        !(use0 && use1));

endmodule

/* logic/dcache_ways.sv */
`timescale 1ns/1ps

module dcache_ways #(
    parameter int index_width = dcache_pkg::DC_INDEX_W
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [dcache_pkg::DC_ADDR_W-1:0] addr,
    input  logic [dcache_pkg::DC_DATA_W-1:0] wdata,
    input  logic [dcache_pkg::DC_STRB_W-1:0] wstrb,
    input  logic [dcache_pkg::DC_DATA_W-1:0] fill_data,
    input  logic [dcache_pkg::DC_WAYS-1:0]   way_we,
    input  logic                             way_refill,
    input  logic                             way_inval,
    output logic [dcache_pkg::DC_WAYS-1:0]   hit,
    output logic [dcache_pkg::DC_DATA_W-1:0] hit_rdata
);
    import dcache_pkg::*;

    localparam int num_sets = 1 << index_width;
    localparam int tag_w    = DC_ADDR_W - index_width - 2;

    logic [index_width-1:0] index;
    logic [tag_w-1:0]       tag;
    logic [DC_DATA_W-1:0]   way_rdata [DC_WAYS];

    assign index = addr[index_width+1:2];
    assign tag   = addr[DC_ADDR_W-1:index_width+2];

    //////////////////////////////////////////////////
    // one bank per way
    //////////////////////////////////////////////////
    for (genvar w = 0; w < DC_WAYS; w++) begin : g_way
        logic [num_sets-1:0]  valid_q;
        logic [tag_w-1:0]     tag_q  [num_sets];
        logic [DC_DATA_W-1:0] data_q [num_sets];

        assign hit[w]       = valid_q[index] && (tag_q[index] == tag);
        assign way_rdata[w] = data_q[index];

        // valid bits, the only state here with a reset
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= '0;
            end else if (way_inval) begin
                valid_q[index] <= 1'b0;
            end else if (way_we[w] && way_refill) begin
                valid_q[index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (way_we[w]) begin
                if (way_refill) begin
                    tag_q[index]  <= tag;
                    data_q[index] <= fill_data;  // whole word from memory
                end else begin
                    // store hit, merge only the strobed bytes
                    for (int b = 0; b < DC_STRB_W; b++) begin
                        if (wstrb[b]) data_q[index][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // read mux, way 0 wins if both ever hit
    assign hit_rdata = hit[0] ? way_rdata[0] : way_rdata[1];

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            rstn,
    // pipeline side
    input  logic                            req_valid,
    input  dcache_pkg::dc_op_e              req_op,
    output logic                            req_ready,
    output logic                            resp_valid,
    output logic [dcache_pkg::DC_DATA_W-1:0] resp_rdata,
    input  logic                            hold,
    // memory side
    output logic                            mem_req,
    output logic                            mem_wr,
    output logic [dcache_pkg::DC_ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::DC_DATA_W-1:0] mem_wdata,
    output logic [dcache_pkg::DC_STRB_W-1:0] mem_wstrb,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    input  logic [dcache_pkg::DC_DATA_W-1:0] mem_rdata,
    // request buffer
    output logic                            buf_we,
    input  dcache_pkg::dc_op_e              buf_op,
    input  logic [dcache_pkg::DC_ADDR_W-1:0] buf_addr,
    input  logic [dcache_pkg::DC_DATA_W-1:0] buf_wdata,
    input  logic [dcache_pkg::DC_STRB_W-1:0] buf_wstrb,
    // ways and lru
    input  logic [dcache_pkg::DC_WAYS-1:0]   hit,
    input  logic [dcache_pkg::DC_DATA_W-1:0] hit_rdata,
    input  logic                            victim,
    output logic                            use0,
    output logic                            use1,
    output logic [dcache_pkg::DC_WAYS-1:0]   way_we,
    output logic                            way_refill,
    output logic                            way_inval
);
    import dcache_pkg::*;

    dc_state_e state, next_state;
    dc_state_e accept_st;             // where a freshly accepted request goes

    assign accept_st = (req_op == OP_INVAL) ? ST_INVAL : ST_LOOKUP;

    // memory port fields come straight from the buffer
    assign mem_addr  = buf_addr;
    assign mem_wdata = buf_wdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state <= ST_IDLE;
        else       state <= next_state;
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (req_valid) next_state = accept_st;
            end
            ST_LOOKUP: begin
                if (buf_op == OP_STORE) next_state = ST_WRITE_THRU;  // hit or miss
                else if (hit == '0)     next_state = ST_REFILL_REQ;
                else if (req_valid)     next_state = accept_st;      // back to back
                else                    next_state = ST_IDLE;
            end
            ST_WRITE_THRU: begin
                if (mem_addr_ok) next_state = req_valid ? accept_st : ST_IDLE;
            end
            ST_REFILL_REQ: begin
                if (mem_addr_ok) next_state = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                if (mem_data_ok) next_state = hold ? ST_REFILL_HOLD : ST_REFILL_DONE;
            end
            ST_REFILL_HOLD: next_state = ST_REFILL_DONE;
            ST_REFILL_DONE: next_state = ST_IDLE;
            ST_INVAL:       next_state = ST_IDLE;
            default:        next_state = ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // strobes, decoded from state and next state
    //////////////////////////////////////////////////
    always_comb begin
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        resp_rdata = hit_rdata;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        mem_wstrb  = '1;          // reads fetch the whole word
        use0       = 1'b0;
        use1       = 1'b0;
        way_we     = '0;
        way_refill = 1'b0;
        way_inval  = 1'b0;
        case (state)
            ST_IDLE: req_ready = 1'b1;
            ST_LOOKUP: begin
                case (next_state)
                    ST_WRITE_THRU: begin
                        way_we = hit;  // zero on a store miss
                        use0   = hit[0];
                        use1   = hit[1];
                    end
                    ST_REFILL_REQ: ;      // request goes out next cycle
                    default: begin        // load hit
                        resp_valid = 1'b1;
                        req_ready  = 1'b1;
                        use0       = hit[0];
                        use1       = hit[1];
                    end
                endcase
            end
            ST_WRITE_THRU: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                mem_wstrb = buf_wstrb;
                if (next_state != ST_WRITE_THRU) req_ready = 1'b1;  // done at addr_ok
            end
            ST_REFILL_REQ: mem_req = 1'b1;
            ST_REFILL_WAIT: begin
                if (next_state != ST_REFILL_WAIT) begin
                    way_refill = 1'b1;
                    way_we     = victim ? 2'b10 : 2'b01;
                    use0       = !victim;
                    use1       = victim;
                    resp_valid = 1'b1;
                    resp_rdata = mem_rdata;  // forward the fill word
                end
            end
            ST_INVAL: way_inval = 1'b1;
            default: ;
        endcase
        buf_we = req_valid && req_ready;
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    // both ways holding the same tag would write both on a store hit
    a_way_we_onehot: assert property (@(posedge clk) disable iff (!rstn)
        way_we != 2'b11);

    a_mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr) && $stable(mem_wr));

    // responses answer loads only, never from idle
    a_no_resp_idle: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> (state != ST_IDLE && buf_op == OP_LOAD));

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int index_width = dcache_pkg::DC_INDEX_W
) (
    input  logic                             clk,
    input  logic                             rstn,
    // pipeline
    input  logic                             req_valid,
    input  dcache_pkg::dc_op_e               req_op,
    input  logic [dcache_pkg::DC_ADDR_W-1:0] req_addr,
    input  logic [dcache_pkg::DC_DATA_W-1:0] req_wdata,
    input  logic [dcache_pkg::DC_STRB_W-1:0] req_wstrb,
    output logic                             req_ready,
    output logic                             resp_valid,
    output logic [dcache_pkg::DC_DATA_W-1:0] resp_rdata,
    input  logic                             hold,
    // memory
    output logic                             mem_req,
    output logic                             mem_wr,
    output logic [dcache_pkg::DC_ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::DC_DATA_W-1:0] mem_wdata,
    output logic [dcache_pkg::DC_STRB_W-1:0] mem_wstrb,
    input  logic                             mem_addr_ok,
    input  logic                             mem_data_ok,
    input  logic [dcache_pkg::DC_DATA_W-1:0] mem_rdata
);
    import dcache_pkg::*;

    logic                 buf_we;
    dc_op_e               buf_op;
    logic [DC_ADDR_W-1:0] buf_addr;
    logic [DC_DATA_W-1:0] buf_wdata;
    logic [DC_STRB_W-1:0] buf_wstrb;
    logic [DC_WAYS-1:0]   hit;
    logic [DC_DATA_W-1:0] hit_rdata;
    logic                 victim;
    logic                 use0;
    logic                 use1;
    logic [DC_WAYS-1:0]   way_we;
    logic                 way_refill;
    logic                 way_inval;

    //////////////////////////////////////////////////
    // controller and request register
    //////////////////////////////////////////////////
    dcache_ctrl u_ctrl (
        .clk, .rstn,
        .req_valid, .req_op, .req_ready, .resp_valid, .resp_rdata, .hold,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb,
        .mem_addr_ok, .mem_data_ok, .mem_rdata,
        .buf_we, .buf_op, .buf_addr, .buf_wdata, .buf_wstrb,
        .hit, .hit_rdata, .victim, .use0, .use1,
        .way_we, .way_refill, .way_inval
    );

    dcache_req_buf u_req_buf (
        .clk, .rstn,
        .we        (buf_we),
        .req_op, .req_addr, .req_wdata, .req_wstrb,
        .buf_op, .buf_addr, .buf_wdata, .buf_wstrb
    );

    //////////////////////////////////////////////////
    // storage, indexed by the buffered address
    //////////////////////////////////////////////////
    dcache_lru #(.index_width(index_width)) u_lru (
        .clk, .rstn,
        .index  (buf_addr[index_width+1:2]),
        .use0, .use1, .victim
    );

    dcache_ways #(.index_width(index_width)) u_ways (
        .clk, .rstn,
        .addr      (buf_addr),
        .wdata     (buf_wdata),
        .wstrb     (buf_wstrb),
        .fill_data (mem_rdata),  // refill writes what memory returns
        .way_we, .way_refill, .way_inval,
        .hit, .hit_rdata
    );

endmodule

/* dv/dcache_mem_model.sv */
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int mem_words = 1024,
    parameter int max_delay = 3     // cycles of random wait per strobe
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             mem_req,
    input  logic                             mem_wr,
    input  logic [dcache_pkg::DC_ADDR_W-1:0] mem_addr,
    input  logic [dcache_pkg::DC_DATA_W-1:0] mem_wdata,
    input  logic [dcache_pkg::DC_STRB_W-1:0] mem_wstrb,
    output logic                             mem_addr_ok,
    output logic                             mem_data_ok,
    output logic [dcache_pkg::DC_DATA_W-1:0] mem_rdata
);
    import dcache_pkg::*;

    localparam int word_aw = $clog2(mem_words);

    logic [DC_DATA_W-1:0] mem [mem_words];
    logic [word_aw-1:0]   rd_word;      // word index of the read in flight
    logic                 rd_pending;
    int unsigned          wait_cnt;

    // every word differs, derived from its full byte address
    function automatic logic [DC_DATA_W-1:0] init_word(input logic [DC_ADDR_W-1:0] byte_addr);
        return (byte_addr * 32'h9e37_79b9) ^ 32'h0bad_cafe;
    endfunction

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] <= init_word(32'(i) << 2);
        end
    end

    //////////////////////////////////////////////////
    // write port, taken at the addr_ok handshake
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rstn && mem_req && mem_addr_ok && mem_wr) begin
            for (int b = 0; b < DC_STRB_W; b++) begin
                if (mem_wstrb[b]) mem[mem_addr[word_aw+1:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // strobes with random delays
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            rd_pending  <= 1'b0;
            rd_word     <= '0;
            wait_cnt    <= 0;
        end else begin
            mem_data_ok <= 1'b0;  // single pulse
            if (mem_req && mem_addr_ok) begin
                mem_addr_ok <= 1'b0;
                wait_cnt    <= $urandom % (max_delay + 1);
                if (!mem_wr) begin
                    rd_pending <= 1'b1;
                    rd_word    <= mem_addr[word_aw+1:2];
                end
            end else if (rd_pending) begin
                if (wait_cnt == 0) begin
                    mem_data_ok <= 1'b1;
                    mem_rdata   <= mem[rd_word];
                    rd_pending  <= 1'b0;
                    wait_cnt    <= $urandom % (max_delay + 1);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req) begin
                if (wait_cnt == 0) mem_addr_ok <= 1'b1;
                else               wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

/* dv/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int          index_width = DC_INDEX_W;
    localparam int          mem_words   = 1024;
    localparam int          word_aw     = $clog2(mem_words);
    localparam int          wait_limit  = 200;  // cycles
    localparam logic [31:0] rng_seed    = 32'h69d0_4121;

    logic                 clk;
    logic                 rstn;
    logic                 req_valid;
    dc_op_e               req_op;
    logic [DC_ADDR_W-1:0] req_addr;
    logic [DC_DATA_W-1:0] req_wdata;
    logic [DC_STRB_W-1:0] req_wstrb;
    logic                 req_ready;
    logic                 resp_valid;
    logic [DC_DATA_W-1:0] resp_rdata;
    logic                 hold;
    logic                 mem_req;
    logic                 mem_wr;
    logic [DC_ADDR_W-1:0] mem_addr;
    logic [DC_DATA_W-1:0] mem_wdata;
    logic [DC_STRB_W-1:0] mem_wstrb;
    logic                 mem_addr_ok;
    logic                 mem_data_ok;
    logic [DC_DATA_W-1:0] mem_rdata;

    int unsigned          err_cnt = 0;
    int unsigned          chk_cnt = 0;
    int unsigned          rd_cnt  = 0;  // reads seen at the mem port
    int unsigned          wr_cnt  = 0;
    logic                 hung    = 1'b0;
    logic [DC_DATA_W-1:0] ref_mem [mem_words];

    dcache_top #(.index_width(index_width)) UUT (
        .clk, .rstn,
        .req_valid, .req_op, .req_addr, .req_wdata, .req_wstrb,
        .req_ready, .resp_valid, .resp_rdata, .hold,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb,
        .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    dcache_mem_model #(.mem_words(mem_words)) u_mem (
        .clk, .rstn,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb,
        .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    always #2 clk = ~clk;

    // memory handshakes, sampled mid cycle
    always @(negedge clk) begin
        if (rstn && mem_req && mem_addr_ok) begin
            if (mem_wr) wr_cnt++;
            else        rd_cnt++;
        end
    end

    initial begin
        wait (hung);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////////////////////////
    // reference image and compare tasks
    //////////////////////////////////////////////////
    function automatic logic [DC_DATA_W-1:0] pattern_word(input logic [DC_ADDR_W-1:0] byte_addr);
        return (byte_addr * 32'h9e37_79b9) ^ 32'h0bad_cafe;
    endfunction

    function automatic logic [DC_DATA_W-1:0] ref_word(input logic [DC_ADDR_W-1:0] addr);
        return ref_mem[addr[word_aw+1:2]];
    endfunction

    task automatic check_data(input string name, input logic [DC_DATA_W-1:0] exp, act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp, act);
        chk_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // parks the caller, the watcher above ends the run
    task automatic stall_forever(input string what);
        dc_state_e st;
        st = UUT.u_ctrl.state;
        $display("timeout: %s, controller stuck in %s", what, st.name());
        hung = 1'b1;
        forever @(posedge clk);
    endtask

    //////////////////////////////////////////////////
    // pipeline drivers
    //////////////////////////////////////////////////
    task automatic wait_ready(input string what);
        int waited;
        waited = 0;
        while (!req_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) stall_forever(what);
    endtask

    task automatic do_load(input logic [DC_ADDR_W-1:0] addr, output logic [DC_DATA_W-1:0] rdata);
        int waited;
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = OP_LOAD;
        req_addr  = addr;
        wait_ready("load never accepted");
        @(negedge clk);  // accepted on the edge just passed
        req_valid = 1'b0;
        waited    = 0;
        while (!resp_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!resp_valid) stall_forever("load never answered");
        rdata = resp_rdata;
    endtask

    task automatic do_store(input logic [DC_ADDR_W-1:0] addr,
                            input logic [DC_DATA_W-1:0] wdata,
                            input logic [DC_STRB_W-1:0] strb);
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = OP_STORE;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        wait_ready("store never accepted");
        @(negedge clk);
        req_valid = 1'b0;
        wait_ready("store never went through");
        @(posedge clk);  // lets the port counter settle
    endtask

    task automatic do_inval(input logic [DC_ADDR_W-1:0] addr);
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = OP_INVAL;
        req_addr  = addr;
        wait_ready("invalidate never accepted");
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic load_and_check(input string name, input logic [DC_ADDR_W-1:0] addr,
                                  input int unsigned reads);
        logic [DC_DATA_W-1:0] rdata;
        int unsigned          rd0;
        rd0 = rd_cnt;
        do_load(addr, rdata);
        check_data({name, " data"}, ref_word(addr), rdata);
        check_count({name, " mem reads"}, reads, rd_cnt - rd0);
    endtask

    task automatic store_and_check(input string name, input logic [DC_ADDR_W-1:0] addr,
                                   input logic [DC_DATA_W-1:0] wdata,
                                   input logic [DC_STRB_W-1:0] strb);
        int unsigned          wr0;
        int unsigned          rd0;
        logic [DC_DATA_W-1:0] word;
        wr0  = wr_cnt;
        rd0  = rd_cnt;
        word = ref_word(addr);
        for (int b = 0; b < DC_STRB_W; b++) begin
            if (strb[b]) word[8*b +: 8] = wdata[8*b +: 8];
        end
        ref_mem[addr[word_aw+1:2]] = word;
        do_store(addr, wdata, strb);
        check_count({name, " mem writes"}, 1, wr_cnt - wr0);
        check_count({name, " mem reads"}, 0, rd_cnt - rd0);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_cold_load();
        load_and_check("cold load", 32'h0000_0100, 1);
        load_and_check("repeat load", 32'h0000_0100, 0);
    endtask

    task automatic test_store_hit();
        store_and_check("store hit", 32'h0000_0100, 32'haabb_ccdd, 4'b0101);
        load_and_check("load after store hit", 32'h0000_0100, 0);
    endtask

    task automatic test_store_miss();
        store_and_check("store miss", 32'h0000_0200, 32'h1122_3344, 4'b1110);
        load_and_check("load after store miss", 32'h0000_0200, 1);
    endtask

    // set 5 for all three
    task automatic test_lru();
        load_and_check("lru load a", 32'h0000_0014, 1);
        load_and_check("lru load b", 32'h0000_0054, 1);
        load_and_check("lru reload a", 32'h0000_0014, 0);
        load_and_check("lru load c", 32'h0000_0094, 1);
        load_and_check("lru a kept", 32'h0000_0014, 0);
        load_and_check("lru b evicted", 32'h0000_0054, 1);
    endtask

    task automatic test_inval();
        do_inval(32'h0000_0014);
        load_and_check("load after inval", 32'h0000_0014, 1);
        load_and_check("other way after inval", 32'h0000_0054, 1);
    endtask

    task automatic test_hold();
        int unsigned gap;
        @(negedge clk);
        hold = 1'b1;
        load_and_check("miss under hold", 32'h0000_0300, 1);
        @(negedge clk);
        hold = 1'b0;
        gap = 1;
        // hold beat, then done, then idle takes requests again
        while (!req_ready && gap < wait_limit) begin
            @(negedge clk);
            gap++;
        end
        check_count("hold stretch cycles", 3, gap);
        load_and_check("hit after hold", 32'h0000_0300, 0);
        load_and_check("neighbor after hold", 32'h0000_0200, 0);
    endtask

    initial begin
        void'($urandom(rng_seed));
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        hold      = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = pattern_word(32'(i) << 2);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_cold_load();
        test_store_hit();
        test_store_miss();
        test_lru();
        test_inval();
        test_hold();

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/dcache_pkg.sv
logic/dcache_req_buf.sv
logic/dcache_lru.sv
logic/dcache_ways.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
